// File: rtl/pic_params.svh
// ==========================================================================
// Interrupt controller sizing macros
// Request count, level number width and the mask value after reset
// ==========================================================================

`ifndef PIC_PARAMS_SVH
`define PIC_PARAMS_SVH

`define PIC_NUM_IRQ 8

`define PIC_LEVEL_W 3

`define PIC_MASK_RESET {`PIC_NUM_IRQ{1'b1}}

`endif

// File: rtl/pic_pkg.sv
// ==========================================================================
// Interrupt controller shared types
// Vector types, host bus and config structs, FSM enums, level conversions
// ==========================================================================

`default_nettype none

`include "pic_params.svh"

package pic_pkg;

    typedef logic [`PIC_NUM_IRQ-1:0]     irq_vec_t;
    typedef logic [`PIC_LEVEL_W-1:0]     irq_level_t;
    typedef logic [7:0]                  bus_data_t;
    typedef logic [7-`PIC_LEVEL_W:0]     vector_base_t;

    typedef struct packed {
        logic       wr;
        logic       a0;
        bus_data_t  data;
    } host_write_t;

    typedef struct packed {
        logic           level_triggered;
        logic           auto_eoi;
        vector_base_t   vector_base;
        irq_vec_t       mask;
    } pic_config_t;

    typedef struct packed {
        logic       valid;
        logic       specific;
        irq_level_t level;
    } eoi_cmd_t;

    typedef enum logic [1:0] {INIT_READY, INIT_ICW2, INIT_ICW4} init_state_t;

    typedef enum logic [1:0] {ACK_IDLE, ACK_WAIT, ACK_FIRST, ACK_SECOND} ack_state_t;

    function automatic irq_vec_t level_to_onehot(input irq_level_t level);
        irq_vec_t vec;
        vec        = '0;
        vec[level] = 1'b1;
        return vec;
    endfunction

    // Lowest set bit wins, all ones when empty
    function automatic irq_level_t onehot_to_level(input irq_vec_t vec);
        irq_level_t level;
        level = '1;
        for (int i = `PIC_NUM_IRQ - 1; i >= 0; i--) begin
            if (vec[i]) begin
                level = irq_level_t'(i);
            end
        end
        return level;
    endfunction

endpackage

`default_nettype wire

// File: rtl/pic_config_regs.sv
// ==========================================================================
// Command word decoder and configuration registers
// ICW1/ICW2/ICW4 init sequence, OCW1 mask, OCW2 EOI commands, OCW3 readback
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pic_params.svh"

module pic_config_regs (
    input  logic                clock,
    input  logic                reset,
    input  pic_pkg::host_write_t host_wr,
    input  logic                read_a0,
    input  pic_pkg::irq_vec_t   irr,
    input  pic_pkg::irq_vec_t   isr,
    output pic_pkg::pic_config_t cfg,
    output pic_pkg::eoi_cmd_t   eoi,
    output pic_pkg::bus_data_t  read_data
);

    pic_pkg::init_state_t   init_state;
    pic_pkg::init_state_t   next_init_state;
    logic                   level_triggered;
    logic                   ic4;
    logic                   auto_eoi;
    pic_pkg::vector_base_t  vector_base;
    pic_pkg::irq_vec_t      mask;
    logic                   read_isr;

    logic   cmd_wr;
    logic   data_wr;
    logic   icw1_wr;
    logic   ocw2_wr;
    logic   ocw3_wr;
    logic   init_done;

    assign cmd_wr    = host_wr.wr & ~host_wr.a0;
    assign data_wr   = host_wr.wr & host_wr.a0;
    assign init_done = (init_state == pic_pkg::INIT_READY);
    assign icw1_wr   = cmd_wr & host_wr.data[4];
    // OCW2/OCW3 are only honoured once initialization is finished
    assign ocw2_wr   = cmd_wr & ~host_wr.data[4] & ~host_wr.data[3] & init_done;
    assign ocw3_wr   = cmd_wr & ~host_wr.data[4] & host_wr.data[3] & init_done;

    always_comb begin
        next_init_state = init_state;
        if (icw1_wr) begin
            next_init_state = pic_pkg::INIT_ICW2;
        end else if (data_wr) begin
            case (init_state)
                pic_pkg::INIT_ICW2: begin
                    if (ic4) begin
                        next_init_state = pic_pkg::INIT_ICW4;
                    end else begin
                        next_init_state = pic_pkg::INIT_READY;
                    end
                end
                pic_pkg::INIT_ICW4: next_init_state = pic_pkg::INIT_READY;
                default:            next_init_state = init_state;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            init_state      <= pic_pkg::INIT_READY;
            level_triggered <= 1'b0;
            ic4             <= 1'b0;
            auto_eoi        <= 1'b0;
            vector_base     <= '0;
            mask            <= `PIC_MASK_RESET;
            read_isr        <= 1'b0;
        end else begin
            init_state <= next_init_state;
            if (icw1_wr) begin
                level_triggered <= host_wr.data[3];
                ic4             <= host_wr.data[0];
                // ICW4 bits fall back to defaults when ICW4 is skipped
                auto_eoi        <= 1'b0;
            end
            if (data_wr && init_state == pic_pkg::INIT_ICW2) begin
                vector_base <= host_wr.data[7:`PIC_LEVEL_W];
            end
            if (data_wr && init_state == pic_pkg::INIT_ICW4) begin
                auto_eoi <= host_wr.data[1];
            end
            if (data_wr && init_done) begin
                mask <= host_wr.data;
            end
            // RR bit gates the RIS update
            if (ocw3_wr && host_wr.data[1]) begin
                read_isr <= host_wr.data[0];
            end
        end
    end

    // EOI pulse straight from the OCW2 write cycle
    always_comb begin
        eoi = '0;
        if (ocw2_wr) begin
            case (host_wr.data[7:5])
                3'b001: eoi.valid = 1'b1;
                3'b011: begin
                    eoi.valid    = 1'b1;
                    eoi.specific = 1'b1;
                end
                default: eoi.valid = 1'b0;
            endcase
            eoi.level = host_wr.data[`PIC_LEVEL_W-1:0];
        end
    end

    always_comb begin
        cfg.level_triggered = level_triggered;
        cfg.auto_eoi        = auto_eoi;
        cfg.vector_base     = vector_base;
        cfg.mask            = mask;
    end

    assign read_data = read_a0 ? mask : (read_isr ? isr : irr);

endmodule

`default_nettype wire

// File: rtl/pic_request_register.sv
// ==========================================================================
// Interrupt request register
// Level or rising-edge capture, cleared on acknowledge in edge mode
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module pic_request_register (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::irq_vec_t    ir,
    input  pic_pkg::pic_config_t cfg,
    input  logic                 latch_in_service,
    input  pic_pkg::irq_vec_t    acked_onehot,
    output pic_pkg::irq_vec_t    irr
);

    pic_pkg::irq_vec_t  ir_prev;
    pic_pkg::irq_vec_t  ir_rise;
    pic_pkg::irq_vec_t  ack_clear;

    assign ir_rise   = ir & ~ir_prev;
    assign ack_clear = latch_in_service ? acked_onehot : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            ir_prev <= '0;
            irr     <= '0;
        end else begin
            ir_prev <= ir;
            if (cfg.level_triggered) begin
                irr <= ir;
            end else begin
                // A new edge in the same cycle as the clear is kept
                irr <= (irr & ~ack_clear) | ir_rise;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pic_in_service.sv
// ==========================================================================
// In-service register
// Set on acknowledge, cleared by non-specific EOI, specific EOI or AEOI
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module pic_in_service (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 latch_in_service,
    input  pic_pkg::irq_vec_t    acked_onehot,
    input  pic_pkg::eoi_cmd_t    eoi,
    input  logic                 ack_done,
    input  pic_pkg::pic_config_t cfg,
    output pic_pkg::irq_vec_t    isr
);

    pic_pkg::irq_vec_t  set_bits;
    pic_pkg::irq_vec_t  eoi_bits;
    pic_pkg::irq_vec_t  aeoi_bits;

    assign set_bits = latch_in_service ? acked_onehot : '0;

    always_comb begin
        if (!eoi.valid) begin
            eoi_bits = '0;
        end else if (eoi.specific) begin
            eoi_bits = pic_pkg::level_to_onehot(eoi.level);
        end else begin
            // Highest priority is the lowest numbered bit
            eoi_bits = pic_pkg::level_to_onehot(pic_pkg::onehot_to_level(isr));
        end
    end

    assign aeoi_bits = (cfg.auto_eoi && ack_done) ? acked_onehot : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            isr <= '0;
        end else begin
            isr <= (isr & ~(eoi_bits | aeoi_bits)) | set_bits;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pic_priority_resolver.sv
// ==========================================================================
// Fixed priority resolver
// IR0 highest, request blocked unless it outranks every in-service level
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module pic_priority_resolver (
    input  pic_pkg::irq_vec_t    irr,
    input  pic_pkg::irq_vec_t    isr,
    input  pic_pkg::pic_config_t cfg,
    output logic                 pending_valid,
    output pic_pkg::irq_level_t  pending_level
);

    pic_pkg::irq_vec_t   masked_irr;
    pic_pkg::irq_level_t isr_level;
    logic                outranks_isr;

    assign masked_irr    = irr & ~cfg.mask;
    assign pending_level = pic_pkg::onehot_to_level(masked_irr);
    assign isr_level     = pic_pkg::onehot_to_level(isr);

    // Equal level stays blocked so a held level request does not re-enter
    assign outranks_isr  = (isr == '0) || (pending_level < isr_level);
    assign pending_valid = (masked_irr != '0) && outranks_isr;

endmodule

`default_nettype wire

// File: rtl/pic_ack_control.sv
// ==========================================================================
// Interrupt acknowledge sequencer
// INT output, two-pulse INTA FSM, acknowledged level latch and vector
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pic_params.svh"

module pic_ack_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 pending_valid,
    input  pic_pkg::irq_level_t  pending_level,
    input  pic_pkg::pic_config_t cfg,
    input  logic                 interrupt_acknowledge_n,
    output logic                 interrupt_to_cpu,
    output logic                 latch_in_service,
    output pic_pkg::irq_vec_t    acked_onehot,
    output logic                 ack_done,
    output logic                 vector_valid,
    output pic_pkg::bus_data_t   vector_data
);

    pic_pkg::ack_state_t  state;
    pic_pkg::ack_state_t  next_state;
    pic_pkg::irq_level_t  acked_level;
    logic                 ack_n_prev;
    logic                 ack_fall;
    logic                 ack_rise;
    logic                 first_ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_n_prev <= 1'b1;
        end else begin
            ack_n_prev <= interrupt_acknowledge_n;
        end
    end

    assign ack_fall  = ack_n_prev & ~interrupt_acknowledge_n;
    assign ack_rise  = ~ack_n_prev & interrupt_acknowledge_n;
    assign first_ack = (state == pic_pkg::ACK_WAIT) && ack_fall;

    always_comb begin
        next_state = state;
        case (state)
            pic_pkg::ACK_IDLE:   if (pending_valid) next_state = pic_pkg::ACK_WAIT;
            pic_pkg::ACK_WAIT:   if (ack_fall)      next_state = pic_pkg::ACK_FIRST;
            pic_pkg::ACK_FIRST:  if (ack_rise)      next_state = pic_pkg::ACK_SECOND;
            pic_pkg::ACK_SECOND: if (ack_rise)      next_state = pic_pkg::ACK_IDLE;
            default:                                next_state = pic_pkg::ACK_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= pic_pkg::ACK_IDLE;
            interrupt_to_cpu <= 1'b0;
            latch_in_service <= 1'b0;
        end else begin
            state            <= next_state;
            interrupt_to_cpu <= (next_state != pic_pkg::ACK_IDLE);
            latch_in_service <= first_ack & pending_valid;
        end
    end

    // Spurious ack reports level 7 with an empty one-hot
    always_ff @(posedge clock) begin
        if (first_ack) begin
            if (pending_valid) begin
                acked_level  <= pending_level;
                acked_onehot <= pic_pkg::level_to_onehot(pending_level);
            end else begin
                acked_level  <= {`PIC_LEVEL_W{1'b1}};
                acked_onehot <= '0;
            end
        end
    end

    assign ack_done     = (state == pic_pkg::ACK_SECOND) && ack_rise;
    assign vector_valid = (state == pic_pkg::ACK_SECOND) && !interrupt_acknowledge_n;
    assign vector_data  = vector_valid ? {cfg.vector_base, acked_level} : '0;

endmodule

`default_nettype wire

// File: rtl/pic_top.sv
// ==========================================================================
// 8086-mode programmable interrupt controller, eight request lines
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module pic_top (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::host_write_t host_wr,
    input  logic                 read_a0,
    output pic_pkg::bus_data_t   read_data,
    input  pic_pkg::irq_vec_t    ir,
    input  logic                 interrupt_acknowledge_n,
    output logic                 interrupt_to_cpu,
    output logic                 vector_valid,
    output pic_pkg::bus_data_t   vector_data
);

    pic_pkg::pic_config_t  cfg;
    pic_pkg::eoi_cmd_t     eoi;
    pic_pkg::irq_vec_t     irr;
    pic_pkg::irq_vec_t     isr;
    pic_pkg::irq_vec_t     acked_onehot;
    pic_pkg::irq_level_t   pending_level;
    logic                  pending_valid;
    logic                  latch_in_service;
    logic                  ack_done;

    pic_config_regs u_config_regs (
        .clock      (clock),
        .reset      (reset),
        .host_wr    (host_wr),
        .read_a0    (read_a0),
        .irr        (irr),
        .isr        (isr),
        .cfg        (cfg),
        .eoi        (eoi),
        .read_data  (read_data)
    );

    pic_request_register u_request_register (
        .clock            (clock),
        .reset            (reset),
        .ir               (ir),
        .cfg              (cfg),
        .latch_in_service (latch_in_service),
        .acked_onehot     (acked_onehot),
        .irr              (irr)
    );

    pic_in_service u_in_service (
        .clock            (clock),
        .reset            (reset),
        .latch_in_service (latch_in_service),
        .acked_onehot     (acked_onehot),
        .eoi              (eoi),
        .ack_done         (ack_done),
        .cfg              (cfg),
        .isr              (isr)
    );

    pic_priority_resolver u_priority_resolver (
        .irr           (irr),
        .isr           (isr),
        .cfg           (cfg),
        .pending_valid (pending_valid),
        .pending_level (pending_level)
    );

    pic_ack_control u_ack_control (
        .clock                   (clock),
        .reset                   (reset),
        .pending_valid           (pending_valid),
        .pending_level           (pending_level),
        .cfg                     (cfg),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .latch_in_service        (latch_in_service),
        .acked_onehot            (acked_onehot),
        .ack_done                (ack_done),
        .vector_valid            (vector_valid),
        .vector_data             (vector_data)
    );

endmodule

`default_nettype wire

// File: verif/pic_checker.sv
// ==========================================================================
// Interrupt controller reference model and output comparisons
// Tracks config, mask, IRR, ISR and the acknowledge FSM from the DUT ports
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "pic_params.svh"

module pic_checker (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::host_write_t host_wr,
    input  logic                 read_a0,
    input  pic_pkg::bus_data_t   read_data,
    input  pic_pkg::irq_vec_t    ir,
    input  logic                 interrupt_acknowledge_n,
    input  logic                 interrupt_to_cpu,
    input  logic                 vector_valid,
    input  pic_pkg::bus_data_t   vector_data,
    output int                   check_count,
    output int                   error_count
);

    pic_pkg::init_state_t   init_state;
    pic_pkg::ack_state_t    ack_state;
    pic_pkg::vector_base_t  base;
    pic_pkg::irq_vec_t      mask;
    pic_pkg::irq_vec_t      irr;
    pic_pkg::irq_vec_t      isr;
    pic_pkg::irq_vec_t      ir_prev;
    pic_pkg::irq_vec_t      acked_bits;
    pic_pkg::irq_level_t    acked_level;
    logic                   ltim;
    logic                   ic4;
    logic                   aeoi;
    logic                   read_isr;
    logic                   int_out;
    logic                   ack_prev;
    logic                   set_pending;

    // Lowest numbered set bit, PIC_NUM_IRQ when empty
    function automatic int lowest_set(input pic_pkg::irq_vec_t vec);
        for (int i = 0; i < `PIC_NUM_IRQ; i++) begin
            if (vec[i]) begin
                return i;
            end
        end
        return `PIC_NUM_IRQ;
    endfunction

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, expected, actual);
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
    end

    always @(posedge clock) begin : model_step
        int                  pend_lvl;
        logic                pend_valid;
        logic                fall;
        logic                rise;
        logic                first_ack;
        logic                done;
        logic                exp_vv;
        pic_pkg::ack_state_t next;
        pic_pkg::irq_vec_t   set_bits;
        pic_pkg::irq_vec_t   eoi_bits;
        pic_pkg::irq_vec_t   aeoi_bits;
        if (reset) begin
            init_state  = pic_pkg::INIT_READY;
            ack_state   = pic_pkg::ACK_IDLE;
            base        = '0;
            mask        = '1;
            irr         = '0;
            isr         = '0;
            ir_prev     = '0;
            acked_bits  = '0;
            acked_level = '1;
            ltim        = 1'b0;
            ic4         = 1'b0;
            aeoi        = 1'b0;
            read_isr    = 1'b0;
            int_out     = 1'b0;
            ack_prev    = 1'b1;
            set_pending = 1'b0;
        end else begin
            exp_vv = (ack_state == pic_pkg::ACK_SECOND) && !interrupt_acknowledge_n;
            compare("interrupt_to_cpu", {7'b0, int_out}, {7'b0, interrupt_to_cpu});
            compare("vector_valid", {7'b0, exp_vv}, {7'b0, vector_valid});
            if (exp_vv) begin
                compare("vector_data", {base, acked_level}, vector_data);
            end
            compare("read_data", read_a0 ? mask : (read_isr ? isr : irr), read_data);

            // Fixed priority, request must outrank every in-service level
            pend_lvl   = lowest_set(irr & ~mask);
            pend_valid = (pend_lvl < `PIC_NUM_IRQ) && (pend_lvl < lowest_set(isr));

            fall      = ack_prev && !interrupt_acknowledge_n;
            rise      = !ack_prev && interrupt_acknowledge_n;
            first_ack = (ack_state == pic_pkg::ACK_WAIT) && fall;
            done      = (ack_state == pic_pkg::ACK_SECOND) && rise;
            next      = ack_state;
            case (ack_state)
                pic_pkg::ACK_IDLE:  if (pend_valid) next = pic_pkg::ACK_WAIT;
                pic_pkg::ACK_WAIT:  if (fall) next = pic_pkg::ACK_FIRST;
                pic_pkg::ACK_FIRST: if (rise) next = pic_pkg::ACK_SECOND;
                default:            if (rise) next = pic_pkg::ACK_IDLE;
            endcase

            set_bits  = set_pending ? acked_bits : '0;
            aeoi_bits = (aeoi && done) ? acked_bits : '0;
            eoi_bits  = '0;
            if (host_wr.wr && !host_wr.a0 && !host_wr.data[4] && !host_wr.data[3]
                    && init_state == pic_pkg::INIT_READY) begin
                if (host_wr.data[7:5] == 3'b001 && isr != '0) begin
                    eoi_bits[lowest_set(isr)] = 1'b1;
                end
                if (host_wr.data[7:5] == 3'b011) begin
                    eoi_bits[host_wr.data[2:0]] = 1'b1;
                end
            end

            if (ltim) begin
                irr = ir;
            end else begin
                irr = (irr & ~set_bits) | (ir & ~ir_prev);
            end
            isr     = (isr & ~(eoi_bits | aeoi_bits)) | set_bits;
            ir_prev = ir;

            // Nothing pending at the first pulse means a spurious ack
            if (first_ack) begin
                acked_bits = '0;
                if (pend_valid) begin
                    acked_level          = pend_lvl[2:0];
                    acked_bits[pend_lvl] = 1'b1;
                end else begin
                    acked_level = '1;
                end
            end
            set_pending = first_ack && pend_valid;
            ack_state   = next;
            int_out     = (next != pic_pkg::ACK_IDLE);
            ack_prev    = interrupt_acknowledge_n;

            if (host_wr.wr && !host_wr.a0 && host_wr.data[4]) begin
                ltim       = host_wr.data[3];
                ic4        = host_wr.data[0];
                aeoi       = 1'b0;
                init_state = pic_pkg::INIT_ICW2;
            end else if (host_wr.wr && host_wr.a0) begin
                case (init_state)
                    pic_pkg::INIT_ICW2: begin
                        base       = host_wr.data[7:3];
                        init_state = ic4 ? pic_pkg::INIT_ICW4 : pic_pkg::INIT_READY;
                    end
                    pic_pkg::INIT_ICW4: begin
                        aeoi       = host_wr.data[1];
                        init_state = pic_pkg::INIT_READY;
                    end
                    default: mask = host_wr.data;
                endcase
            end else if (host_wr.wr && !host_wr.a0 && host_wr.data[3] && host_wr.data[1]
                    && init_state == pic_pkg::INIT_READY) begin
                read_isr = host_wr.data[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_pic.sv
// ==========================================================================
// Interrupt controller testbench
// Clock, reset, xorshift stimulus, CPU acknowledge pulses, test sequence
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_pic;

    logic                 clock;
    logic                 reset;
    pic_pkg::host_write_t host_wr;
    logic                 read_a0;
    pic_pkg::bus_data_t   read_data;
    pic_pkg::irq_vec_t    ir;
    logic                 interrupt_acknowledge_n;
    logic                 interrupt_to_cpu;
    logic                 vector_valid;
    pic_pkg::bus_data_t   vector_data;
    int                   check_count;
    int                   error_count;
    int                   timeout_count;
    int                   errors_before;
    logic [31:0]          rand_state;

    pic_top u_pic_top (
        .clock                   (clock),
        .reset                   (reset),
        .host_wr                 (host_wr),
        .read_a0                 (read_a0),
        .read_data               (read_data),
        .ir                      (ir),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .vector_valid            (vector_valid),
        .vector_data             (vector_data)
    );

    pic_checker u_pic_checker (
        .clock                   (clock),
        .reset                   (reset),
        .host_wr                 (host_wr),
        .read_a0                 (read_a0),
        .read_data               (read_data),
        .ir                      (ir),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .vector_valid            (vector_valid),
        .vector_data             (vector_data),
        .check_count             (check_count),
        .error_count             (error_count)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        rand_state = xorshift(rand_state);
        return rand_state;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        reset                   = 1'b1;
        host_wr                 = '0;
        read_a0                 = 1'b0;
        ir                      = '0;
        interrupt_acknowledge_n = 1'b1;
        repeat (2) step();
        reset = 1'b0;
    endtask

    task automatic write_reg(input logic a0, input pic_pkg::bus_data_t data);
        host_wr.wr   = 1'b1;
        host_wr.a0   = a0;
        host_wr.data = data;
        step();
        host_wr = '0;
    endtask

    // ICW1 with IC4, ICW2, ICW4 with the 8086 bit
    task automatic init_pic(input logic ltim, input logic aeoi,
                            input pic_pkg::vector_base_t base);
        write_reg(1'b0, {4'b0001, ltim, 3'b001});
        write_reg(1'b1, {base, 3'b000});
        write_reg(1'b1, {6'b0, aeoi, 1'b1});
    endtask

    task automatic wait_interrupt(input int limit);
        int n;
        n = 0;
        while (!interrupt_to_cpu && n < limit) begin
            step();
            n++;
        end
        if (!interrupt_to_cpu) begin
            $display("ERROR: interrupt_to_cpu did not rise within %0d cycles", limit);
            timeout_count++;
        end
    endtask

    task automatic ack_pulse();
        interrupt_acknowledge_n = 1'b0;
        repeat (2) step();
        interrupt_acknowledge_n = 1'b1;
        repeat (2) step();
    endtask

    task automatic ack_sequence();
        ack_pulse();
        ack_pulse();
    endtask

    task automatic end_test(input int number, input string name);
        int errors;
        errors        = error_count + timeout_count - errors_before;
        errors_before = error_count + timeout_count;
        $display("test %0d %s: %0d errors", number, name, errors);
    endtask

    initial begin : test_sequence
        logic [31:0] r;
        int          a;
        int          b;
        clock                   = 1'b0;
        reset                   = 1'b1;
        host_wr                 = '0;
        read_a0                 = 1'b0;
        ir                      = '0;
        interrupt_acknowledge_n = 1'b1;
        rand_state              = 32'h4ca7_8008;
        timeout_count           = 0;
        errors_before           = 0;

        // Mask readback across reset, init and OCW1
        apply_reset();
        read_a0 = 1'b1;
        step();
        r = draw_random();
        init_pic(r[0], 1'b0, r[15:11]);
        write_reg(1'b1, r[23:16]);
        step();
        end_test(1, "mask readback");

        // Bit 7 always requested and unmasked
        apply_reset();
        r = draw_random();
        init_pic(r[0], 1'b0, r[15:11]);
        write_reg(1'b1, r[23:16] & 8'h7f);
        for (int i = 0; i < 6; i++) begin
            r  = draw_random();
            ir = r[7:0] | 8'h80;
            wait_interrupt(4);
            ack_sequence();
            ir = '0;
            write_reg(1'b0, 8'h20);
            step();
        end
        end_test(2, "vector sequence");

        apply_reset();
        r = draw_random();
        init_pic(1'b0, 1'b0, r[15:11]);
        write_reg(1'b1, 8'h00);
        write_reg(1'b0, 8'h0b);
        a     = int'(r % 7);
        b     = a + 1 + int'(r[23:16]) % (7 - a);
        ir[b] = 1'b1;
        wait_interrupt(4);
        ack_sequence();
        ir[a] = 1'b1;
        wait_interrupt(4);
        ack_sequence();
        write_reg(1'b0, 8'h20);
        step();
        write_reg(1'b0, {5'b01100, b[2:0]});
        ir = '0;
        step();
        end_test(3, "in-service and EOI");

        apply_reset();
        r = draw_random();
        init_pic(r[0], 1'b1, r[15:11]);
        write_reg(1'b1, 8'h00);
        write_reg(1'b0, 8'h0b);
        for (int i = 0; i < 4; i++) begin
            r            = draw_random();
            ir           = '0;
            ir[r[2:0]]   = 1'b1;
            wait_interrupt(4);
            ack_sequence();
            ir = '0;
            repeat (2) step();
        end
        end_test(4, "automatic EOI");

        // Lower request blocked, higher request nests
        apply_reset();
        r = draw_random();
        init_pic(1'b0, 1'b0, r[15:11]);
        write_reg(1'b1, 8'h00);
        a     = 1 + int'(r % 6);
        ir[a] = 1'b1;
        wait_interrupt(4);
        ack_sequence();
        b     = a + 1 + int'(r[23:16]) % (7 - a);
        ir[b] = 1'b1;
        repeat (4) step();
        b     = int'(r[31:24]) % a;
        ir[b] = 1'b1;
        wait_interrupt(2);
        ack_sequence();
        end_test(5, "nesting");

        apply_reset();
        r = draw_random();
        init_pic(1'b0, 1'b0, r[15:11]);
        write_reg(1'b1, 8'hff);
        write_reg(1'b0, 8'h0a);
        ir = r[23:16];
        step();
        ir = '0;
        repeat (3) step();
        // Level mode without ICW4
        write_reg(1'b0, 8'h18);
        write_reg(1'b1, {r[15:11], 3'b000});
        for (int i = 0; i < 4; i++) begin
            r  = draw_random();
            ir = r[7:0];
            repeat (2) step();
        end
        end_test(6, "IRR readback");

        $display("tests 6, checks %0d, errors %0d", check_count, error_count + timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/pic_pkg.sv
rtl/pic_config_regs.sv
rtl/pic_request_register.sv
rtl/pic_in_service.sv
rtl/pic_priority_resolver.sv
rtl/pic_ack_control.sv
rtl/pic_top.sv
verif/pic_checker.sv
verif/tb_pic.sv

// File: Bender.yml
package:
  name: pic

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pic_pkg.sv
      - rtl/pic_config_regs.sv
      - rtl/pic_request_register.sv
      - rtl/pic_in_service.sv
      - rtl/pic_priority_resolver.sv
      - rtl/pic_ack_control.sv
      - rtl/pic_top.sv
      - target: test
        files:
          - verif/pic_checker.sv
          - verif/tb_pic.sv
